// File: verilog/ps2_pkg.sv
// shared ps2 keyboard codes and sizes; fifo_depth must stay a power of two equal to 2**fifo_addr_w
package ps2_pkg;

	// one byte as it comes off the ps2 line
	typedef logic [7:0] scan_t;

	// protocol bytes
	localparam scan_t code_break       = 8'hf0; // key released, next byte repeats the key
	localparam scan_t code_shift_left  = 8'h12;
	localparam scan_t code_shift_right = 8'h59;
	localparam scan_t code_caps        = 8'h58;

	// receiver sizing
	localparam int filter_len = 8;  // equal samples before the filtered clock flips
	localparam int frame_bits = 11; // start, 8 data, parity, stop

	// scan byte buffer
	localparam int fifo_depth  = 8;
	localparam int fifo_addr_w = 3; // log2 of fifo_depth

	// key tracker states, same order as the original keyboard fsm
	typedef enum logic [2:0]
	{
		lowercase,
		ignore_break,       // swallow the byte after f0
		shift_held,
		ignore_shift_break, // f0 seen while shifted
		caps_lock,
		ignore_caps_break   // f0 seen while in caps lock
	} key_state_t;

	// commands to the ship, 0 is unused
	typedef enum logic [3:0]
	{
		left     = 4'd1,
		right    = 4'd2,
		down     = 4'd3,
		up       = 4'd4,
		fire     = 4'd5,
		p2_up    = 4'd6,
		p2_left  = 4'd7,
		p2_down  = 4'd8,
		p2_right = 4'd9
	} ship_cmd_t;

	// caps bytes still expected before caps lock ends
	typedef logic [1:0] caps_count_t;

endpackage

// File: verilog/ps2_frame_rx.sv
// ps2 device-to-host frames only; no timeout, so a frame cut short is completed by the next one
`timescale 1ns/1ps

module ps2_frame_rx
(
	input  logic           clock,
	input  logic           reset,
	input  logic           ps2_clock, // async line from the keyboard
	input  logic           ps2_data,  // async, sampled on falling ps2_clock
	output logic           rx_valid,
	output ps2_pkg::scan_t rx_code
);
	import ps2_pkg::*;

	logic [1:0] clock_sync;            // two-flop synchronizer, ps2 clock
	logic [1:0] data_sync;             // two-flop synchronizer, ps2 data
	logic [filter_len-1:0] filter;     // recent clock samples
	logic filt_level;                  // filtered ps2 clock
	logic filt_next;
	logic fall;                        // filtered clock 1 -> 0 this cycle
	logic receiving;                   // inside a frame
	logic [3:0] bit_cnt;               // bits already captured
	logic [frame_bits-1:0] frame;      // lsb first, start bit ends up in bit 0
	logic [frame_bits-1:0] frame_next;
	logic last_bit;                    // current edge samples the stop bit
	logic frame_ok;

	// hysteresis, level only moves when the whole window agrees
	always_comb
	begin
		if (&filter)
			filt_next = 1'b1;
		else if (~|filter)
			filt_next = 1'b0;
		else
			filt_next = filt_level;
	end

	assign fall = filt_level & ~filt_next;

	assign frame_next = {data_sync[1], frame[frame_bits-1:1]}; // shift right, new bit at top
	assign last_bit   = receiving && (bit_cnt == 4'(frame_bits - 1));

	// start low, stop high, odd parity over data plus parity bit
	assign frame_ok = ~frame_next[0]
		& frame_next[frame_bits-1]
		& (^frame_next[frame_bits-2:1]);

	// control side
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			clock_sync <= 2'b11; // idle bus is high
			data_sync  <= 2'b11;
			filter     <= '1;
			filt_level <= 1'b1;
			receiving  <= 1'b0;
			bit_cnt    <= '0;
			rx_valid   <= 1'b0;
		end
		else
		begin
			clock_sync <= {clock_sync[0], ps2_clock};
			data_sync  <= {data_sync[0], ps2_data};
			filter     <= {clock_sync[1], filter[filter_len-1:1]};
			filt_level <= filt_next;
			rx_valid   <= 1'b0; // single cycle pulse

			if (fall)
			begin
				if (!receiving)
				begin
					receiving <= 1'b1; // this edge took the start bit
					bit_cnt   <= 4'd1;
				end
				else if (last_bit)
				begin
					receiving <= 1'b0;
					bit_cnt   <= '0;
					rx_valid  <= frame_ok; // bad frames just vanish
				end
				else
					bit_cnt <= bit_cnt + 4'd1;
			end
		end
	end

	// payload side
	always_ff @(posedge clock)
	begin
		if (fall)
			frame <= frame_next;
		if (fall && last_bit)
			rx_code <= frame_next[8:1]; // data byte, lands with rx_valid
	end

	// a frame takes many ps2 edges, two back to back pulses mean the counter broke
	assert property (@(posedge clock) disable iff (reset) rx_valid |=> !rx_valid)
		else $error("rx_valid high for two cycles");

endmodule

// File: verilog/scan_fifo.sv
// push side has no ready; a push into a full buffer without a pop in the same cycle is lost
`timescale 1ns/1ps

module scan_fifo
(
	input  logic           clock,
	input  logic           reset,
	input  logic           push,
	input  ps2_pkg::scan_t push_code,
	output logic           pop_valid,
	output ps2_pkg::scan_t pop_code,  // head entry
	input  logic           pop_ready
);
	import ps2_pkg::*;

	scan_t mem [fifo_depth];            // circular storage
	logic [fifo_addr_w-1:0] wr_ptr;
	logic [fifo_addr_w-1:0] rd_ptr;
	logic [fifo_addr_w:0] count;        // occupancy, 0..fifo_depth
	logic full;
	logic do_push;
	logic do_pop;

	assign full      = (count == (fifo_addr_w + 1)'(fifo_depth));
	assign pop_valid = (count != '0);
	assign pop_code  = mem[rd_ptr];
	assign do_pop    = pop_valid & pop_ready;
	assign do_push   = push & (~full | do_pop); // full but popping, room frees this edge

	// pointers and count
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;

			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	// storage write
	always_ff @(posedge clock)
	begin
		if (do_push)
			mem[wr_ptr] <= push_code;
	end

	assert property (@(posedge clock) disable iff (reset)
		count <= (fifo_addr_w + 1)'(fifo_depth))
		else $error("fifo occupancy above depth");

	// head must not move under a stalled consumer
	assert property (@(posedge clock) disable iff (reset)
		pop_valid && !pop_ready |=> $stable(pop_code))
		else $error("pop_code changed while stalled");

endmodule

// File: verilog/key_tracker.sv
// one command held at a time; no byte is taken while a command waits, shift and caps do not stack
`timescale 1ns/1ps

module key_tracker
(
	input  logic               clock,
	input  logic               reset,
	input  logic               code_valid,
	input  ps2_pkg::scan_t     code,
	output logic               code_ready,
	output logic               cmd_valid,
	output ps2_pkg::ship_cmd_t cmd,
	output logic               cmd_upper,
	input  logic               cmd_ready
);
	import ps2_pkg::*;

	key_state_t state;
	key_state_t state_next;
	scan_t shift_key;        // which shift went down
	scan_t shift_next;
	caps_count_t caps_left;  // caps bytes before lock ends
	caps_count_t caps_next;
	logic pop;               // byte taken this cycle
	logic is_shift;
	logic upper;             // case at the moment of the pop
	logic load;              // popped byte makes a command

	// scan code to ship command, unknown keys default to up
	function automatic ship_cmd_t map_scan(input scan_t sc);
		case (sc)
			8'h1c: return left;     // a
			8'h23: return right;    // d
			8'h1b: return down;     // s
			8'h1d: return up;       // w
			8'h29: return fire;     // space
			8'h75: return p2_up;    // arrow keys for a second player
			8'h6b: return p2_left;
			8'h72: return p2_down;
			8'h74: return p2_right;
			default: return up;
		endcase
	endfunction

	assign code_ready = ~cmd_valid;
	assign pop        = code_valid & code_ready;
	assign is_shift   = (code == code_shift_left) || (code == code_shift_right);
	assign upper      = (state == shift_held) || (state == caps_lock);

	always_comb
	begin
		state_next = state;
		shift_next = shift_key;
		caps_next  = caps_left;
		load       = 1'b0;

		if (pop)
		begin
			case (state)
				lowercase:
				begin
					if (is_shift)
					begin
						shift_next = code;
						state_next = shift_held;
					end
					else if (code == code_caps)
					begin
						caps_next  = 2'd3; // press, release, press, release
						state_next = caps_lock;
					end
					else if (code == code_break)
						state_next = ignore_break;
					else
						load = 1'b1;
				end

				ignore_break:
					state_next = lowercase; // repeated key code

				shift_held:
				begin
					if (code == code_break)
						state_next = ignore_shift_break;
					else if (!is_shift && code != code_caps)
						load = 1'b1; // shift repeats and caps ignored
				end

				ignore_shift_break:
					state_next = (code == shift_key) ? lowercase : shift_held;

				caps_lock:
				begin
					if (code == code_caps)
					begin
						caps_next = caps_left - 2'd1;
						if (caps_left == 2'd1)
							state_next = lowercase; // count hits zero
					end
					else if (code == code_break)
						state_next = ignore_caps_break;
					else if (!is_shift)
						load = 1'b1;
				end

				ignore_caps_break:
				begin
					state_next = caps_lock;
					if (code == code_caps)
					begin
						caps_next = caps_left - 2'd1; // released caps counts too
						if (caps_left == 2'd1)
							state_next = lowercase;
					end
				end

				default:
					state_next = lowercase;
			endcase
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state     <= lowercase;
			shift_key <= '0;
			caps_left <= '0;
			cmd_valid <= 1'b0;
		end
		else
		begin
			state     <= state_next;
			shift_key <= shift_next;
			caps_left <= caps_next;
			if (load)
				cmd_valid <= 1'b1;
			else if (cmd_ready)
				cmd_valid <= 1'b0; // handshake done
		end
	end

	// output register, only loads while cmd_valid is low
	always_ff @(posedge clock)
	begin
		if (load)
		begin
			cmd       <= map_scan(code);
			cmd_upper <= upper;
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		cmd_valid && !cmd_ready |=> $stable(cmd) && $stable(cmd_upper))
		else $error("command changed while stalled");

endmodule

// File: verilog/keyboard_top.sv
// ps2 keyboard to ship commands; ps2 lines are async, frames lost once the scan fifo fills
`timescale 1ns/1ps

module keyboard_top
(
	input  logic               clock,
	input  logic               reset,
	input  logic               ps2_clock,
	input  logic               ps2_data,
	output logic               cmd_valid,
	output ps2_pkg::ship_cmd_t cmd,
	output logic               cmd_upper,
	input  logic               cmd_ready
);
	import ps2_pkg::*;

	logic  rx_valid;   // one pulse per good frame
	scan_t rx_code;
	logic  fifo_valid;
	scan_t fifo_code;
	logic  fifo_ready; // tracker free

	ps2_frame_rx u_rx
	(
		.clock     (clock),
		.reset     (reset),
		.ps2_clock (ps2_clock),
		.ps2_data  (ps2_data),
		.rx_valid  (rx_valid),
		.rx_code   (rx_code)
	);

	scan_fifo u_fifo
	(
		.clock     (clock),
		.reset     (reset),
		.push      (rx_valid),
		.push_code (rx_code),
		.pop_valid (fifo_valid),
		.pop_code  (fifo_code),
		.pop_ready (fifo_ready)
	);

	key_tracker u_tracker
	(
		.clock      (clock),
		.reset      (reset),
		.code_valid (fifo_valid),
		.code       (fifo_code),
		.code_ready (fifo_ready),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd),
		.cmd_upper  (cmd_upper),
		.cmd_ready  (cmd_ready)
	);

endmodule

// File: include/ps2_stim.svh
// stimulus helpers for keyboard_tb; included inside the module, uses its clock and ps2 signals
`ifndef ps2_stim_svh
`define ps2_stim_svh

	localparam int half_period = 40; // system clocks per ps2 clock phase

	// 32 bit lcg, upper bits are the useful ones
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// the nine keys that have a command of their own
	function automatic logic [7:0] mapped_code(input int idx);
		case (idx)
			0: return 8'h1c;
			1: return 8'h23;
			2: return 8'h1b;
			3: return 8'h1d;
			4: return 8'h29;
			5: return 8'h75;
			6: return 8'h6b;
			7: return 8'h72;
			default: return 8'h74;
		endcase
	endfunction

	// {upper, command}, unknown keys give up
	function automatic logic [4:0] expected_cmd(input logic [7:0] code, input logic upper);
		logic [3:0] c;
		case (code)
			8'h1c: c = 4'd1;
			8'h23: c = 4'd2;
			8'h1b: c = 4'd3;
			8'h29: c = 4'd5;
			8'h75: c = 4'd6;
			8'h6b: c = 4'd7;
			8'h72: c = 4'd8;
			8'h74: c = 4'd9;
			default: c = 4'd4;
		endcase
		return {upper, c};
	endfunction

	// one device to host frame, data set while clock high, lsb first
	task automatic send_frame(input logic [7:0] code, input logic bad_parity);
		logic [10:0] bits;
		int i;
		bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0}; // stop, parity, data, start
		for (i = 0; i < 11; i++)
		begin
			@(posedge clock);
			ps2_data <= bits[i];
			repeat (half_period) @(posedge clock);
			ps2_clock <= 1'b0; // receiver samples here
			repeat (half_period) @(posedge clock);
			ps2_clock <= 1'b1;
		end
		ps2_data <= 1'b1;
		repeat (20) @(posedge clock); // idle gap
	endtask

`endif

// File: tests/keyboard_tb.sv
// keyboard_top testbench; ps2 lines driven ideal and glitch free, watchdog sized for 40 frames
`timescale 1ns/1ps

module keyboard_tb;
	import ps2_pkg::*;

	localparam int total_frames    = 40;    // frames sent over all tests
	localparam int watchdog_cycles = total_frames * frame_bits * 80 + 20000;
	localparam int drain_limit     = 20000; // cycles to wait for pending commands
	localparam int settle_cycles   = 100;   // quiet time for stray commands

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic ps2_clock = 1'b1;  // idle bus high
	logic ps2_data = 1'b1;
	logic cmd_ready = 1'b1;
	logic cmd_valid;
	ship_cmd_t cmd;
	logic cmd_upper;

	logic [4:0] exp_q [$];   // {upper, cmd} in arrival order
	logic case_upper = 1'b0; // tb view of shift or caps lock
	logic [1:0] ready_mode = 2'd1; // 0 held low, 1 random stalls, 2 held high
	logic [31:0] key_seed = 32'd57;
	logic [31:0] stall_seed = 32'd57;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int errors_mark = 0;     // errors before the current test

	`include "ps2_stim.svh"

	always #10 clock = ~clock; // 20 ns period

	keyboard_top UUT
	(
		.clock     (clock),
		.reset     (reset),
		.ps2_clock (ps2_clock),
		.ps2_data  (ps2_data),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.cmd_upper (cmd_upper),
		.cmd_ready (cmd_ready)
	);

	task automatic check_value(input string name, input int got, input int want);
		checks++;
		if (got != want)
		begin
			errors++;
			$display("error at %0d ns: %s got %0d expected %0d", $time, name, got, want);
		end
	endtask

	// expected result pushed before the frame goes out, the command can beat the task's return
	task automatic press_key(input logic [7:0] code);
		exp_q.push_back(expected_cmd(code, case_upper));
		send_frame(code, 1'b0);
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < drain_limit)
		begin
			@(posedge clock);
			waited++;
		end
		if (exp_q.size() != 0)
		begin
			$display("%0d expected commands never arrived by %0d ns", exp_q.size(), $time);
			errors++;
			exp_q.delete();
		end
		repeat (settle_cycles) @(posedge clock); // extra commands show up here
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == errors_mark)
			$display("test %0d %s: ok", tests_run, name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - errors_mark);
		end
		errors_mark = errors;
	endtask

	// cmd_ready pattern
	always @(posedge clock)
	begin
		case (ready_mode)
			2'd0: cmd_ready <= 1'b0;
			2'd1:
			begin
				stall_seed = lcg_next(stall_seed);
				cmd_ready <= (stall_seed[17:16] != 2'b00); // high three times in four
			end
			default: cmd_ready <= 1'b1;
		endcase
	end

	// compare at every command handshake
	always @(posedge clock)
	begin
		logic [4:0] want;
		if (!reset && cmd_valid && cmd_ready)
		begin
			if (exp_q.size() == 0)
			begin
				$display("unexpected command %0d at %0d ns with nothing pending", cmd, $time);
				errors++;
			end
			else
			begin
				want = exp_q.pop_front();
				check_value("cmd", int'(cmd), int'(want[3:0]));
				check_value("cmd_upper", int'(cmd_upper), int'(want[4]));
			end
		end
	end

	initial
	begin
		int i;
		logic [7:0] pick;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		repeat (5) @(posedge clock);

		// all mapped keys, then one the map does not know
		for (i = 0; i < 9; i++)
			press_key(mapped_code(i));
		press_key(8'h15); // q
		wait_drain();
		finish_test("plain make codes");

		press_key(8'h1c);
		send_frame(code_break, 1'b0);
		send_frame(8'h1c, 1'b0); // repeated code after f0, no command
		wait_drain();
		finish_test("make and break");

		send_frame(code_shift_left, 1'b0);
		case_upper = 1'b1;
		press_key(8'h23);
		press_key(8'h75);
		send_frame(code_break, 1'b0);
		send_frame(code_shift_left, 1'b0);
		case_upper = 1'b0;
		press_key(8'h1b);
		send_frame(code_shift_right, 1'b0);
		case_upper = 1'b1;
		press_key(8'h1d);
		send_frame(code_break, 1'b0);
		send_frame(code_shift_right, 1'b0);
		case_upper = 1'b0;
		press_key(8'h6b);
		wait_drain();
		finish_test("shift left and right");

		// caps lock lasts four caps bytes
		send_frame(code_caps, 1'b0);
		case_upper = 1'b1;
		press_key(8'h29);
		send_frame(code_break, 1'b0);
		send_frame(code_caps, 1'b0);
		press_key(8'h72);
		send_frame(code_caps, 1'b0);
		press_key(8'h74);
		send_frame(code_break, 1'b0);
		send_frame(code_caps, 1'b0);
		case_upper = 1'b0;
		press_key(8'h1c);
		wait_drain();
		finish_test("caps lock");

		send_frame(8'h23, 1'b1); // wrong parity, dropped
		press_key(8'h1d);
		wait_drain();
		finish_test("parity error");

		@(posedge clock);
		ready_mode <= 2'd0;
		repeat (3) @(posedge clock);
		for (i = 0; i < 4; i++)
		begin
			key_seed = lcg_next(key_seed);
			pick = mapped_code(int'(key_seed[30:16]) % 9);
			press_key(pick);
		end
		repeat (settle_cycles) @(posedge clock);
		check_value("cmd_valid", int'(cmd_valid), 1);
		check_value("cmd", int'(cmd), int'(exp_q[0][3:0])); // first key held on the bus
		check_value("cmd_upper", int'(cmd_upper), int'(exp_q[0][4]));
		ready_mode <= 2'd1;
		wait_drain();
		finish_test("stalled output");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("timeout, run still going after %0d cycles", watchdog_cycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+include
verilog/ps2_pkg.sv
verilog/ps2_frame_rx.sv
verilog/scan_fifo.sv
verilog/key_tracker.sv
verilog/keyboard_top.sv
tests/keyboard_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile keyboard_tb with verilator, run it and read the verdict from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f \
	--top-module keyboard_tb \
	-o keyboard_sim

./obj_dir/keyboard_sim | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log
then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
